/* hdl/vision_pkg.sv */
package vision_pkg;

    // Vector types with a meaning of their own
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [15:0] rgb565_t;   // 5:6:5 packed pixel
    typedef logic [7:0]  channel_t;
    typedef logic [3:0]  wb_adr_t;
    typedef logic [7:0]  wb_data_t;

    typedef enum logic [1:0] {
        MODE_CAMERA = 2'd0,
        MODE_GREY   = 2'd1,
        MODE_MASK   = 2'd2   // Threshold result as black and white
    } display_mode_t;

    // Reduced raster so a frame simulates quickly
    localparam hcount_t H_ACTIVE     = 11'd64;
    localparam hcount_t H_TOTAL      = 11'd80;
    localparam hcount_t H_SYNC_START = 11'd68;
    localparam hcount_t H_SYNC_END   = 11'd72;
    localparam vcount_t V_ACTIVE     = 10'd32;
    localparam vcount_t V_TOTAL      = 10'd36;
    localparam vcount_t V_SYNC_START = 10'd33;
    localparam vcount_t V_SYNC_END   = 10'd34;

    localparam int SCALE_SHIFT = 2;   // 4x in each direction
    localparam int FB_WIDTH    = int'(H_ACTIVE) >> SCALE_SHIFT;
    localparam int FB_HEIGHT   = int'(V_ACTIVE) >> SCALE_SHIFT;
    localparam int FB_DEPTH    = FB_WIDTH * FB_HEIGHT;

    typedef logic [$clog2(FB_DEPTH)-1:0] fb_addr_t;

    // Address register, read, then the colour stage
    localparam int PIPE_DELAY = 3;

    localparam wb_adr_t  REG_LOWER   = 4'd0;
    localparam wb_adr_t  REG_UPPER   = 4'd1;
    localparam wb_adr_t  REG_MODE    = 4'd2;
    localparam channel_t LOWER_RESET = 8'd240;
    localparam channel_t UPPER_RESET = 8'd255;

endpackage

/* hdl/pixel_if.sv */
`timescale 1ns/1ps

interface pixel_if;

    logic                valid;    // Pixel present this cycle
    vision_pkg::hcount_t hcount;
    vision_pkg::vcount_t vcount;
    vision_pkg::rgb565_t pixel;

    // Camera side drives the stream
    modport source (
        output valid,
        output hcount,
        output vcount,
        output pixel
    );

    // No ready signal, the sink takes every valid pixel
    modport sink (
        input valid,
        input hcount,
        input vcount,
        input pixel
    );

endinterface

/* hdl/wb_ctrl_regs.sv */
`timescale 1ns/1ps

module wb_ctrl_regs (
    input  logic                      clk_pixel,
    input  logic                      recent_reset,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  vision_pkg::wb_adr_t       wb_adr_i,
    input  vision_pkg::wb_data_t      wb_dat_i,
    output vision_pkg::wb_data_t      wb_dat_o,
    output logic                      wb_ack_o,
    output vision_pkg::channel_t      lower_o,
    output vision_pkg::channel_t      upper_o,
    output vision_pkg::display_mode_t mode_o
);

    logic req;   // New access, not yet acknowledged

    // Ack drops after one cycle even with stb held
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            wb_ack_o <= 1'b0;
            lower_o  <= vision_pkg::LOWER_RESET;
            upper_o  <= vision_pkg::UPPER_RESET;
            mode_o   <= vision_pkg::MODE_CAMERA;
        end else begin
            wb_ack_o <= req;
            if (req && wb_we_i) begin
                case (wb_adr_i)
                    vision_pkg::REG_LOWER: lower_o <= wb_dat_i;
                    vision_pkg::REG_UPPER: upper_o <= wb_dat_i;
                    vision_pkg::REG_MODE:
                        mode_o <= vision_pkg::display_mode_t'(wb_dat_i[1:0]);
                    default: ;   // Unmapped, write dropped
                endcase
            end
        end
    end

    // Read data lines up with the ack cycle
    always_ff @(posedge clk_pixel) begin
        if (req) begin
            case (wb_adr_i)
                vision_pkg::REG_LOWER: wb_dat_o <= lower_o;
                vision_pkg::REG_UPPER: wb_dat_o <= upper_o;
                vision_pkg::REG_MODE:  wb_dat_o <= {6'd0, mode_o};
                default:               wb_dat_o <= '0;
            endcase
        end
    end

endmodule

/* hdl/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
    input  logic                clk_pixel,
    input  logic                recent_reset,
    output vision_pkg::hcount_t scan_h_o,
    output vision_pkg::vcount_t scan_v_o,
    output logic                scan_active_o,
    output vision_pkg::hcount_t hcount_o,
    output vision_pkg::vcount_t vcount_o,
    output logic                active_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                new_frame_o
);

    vision_pkg::hcount_t h_cnt;
    vision_pkg::vcount_t v_cnt;
    logic [3:0]          flags;   // active, hsync, vsync, frame start

    vision_pkg::hcount_t h_dly    [vision_pkg::PIPE_DELAY];
    vision_pkg::vcount_t v_dly    [vision_pkg::PIPE_DELAY];
    logic [3:0]          flag_dly [vision_pkg::PIPE_DELAY];

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == vision_pkg::H_TOTAL - 1'b1) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == vision_pkg::V_TOTAL - 1'b1) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign scan_h_o      = h_cnt;
    assign scan_v_o      = v_cnt;
    assign scan_active_o = (h_cnt < vision_pkg::H_ACTIVE) && (v_cnt < vision_pkg::V_ACTIVE);

    assign flags[3] = scan_active_o;
    assign flags[2] = (h_cnt >= vision_pkg::H_SYNC_START) && (h_cnt < vision_pkg::H_SYNC_END);
    assign flags[1] = (v_cnt >= vision_pkg::V_SYNC_START) && (v_cnt < vision_pkg::V_SYNC_END);
    assign flags[0] = (h_cnt == '0) && (v_cnt == '0);

    // Match the latency of pixel_classify
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            for (int i = 0; i < vision_pkg::PIPE_DELAY; i++) begin
                h_dly[i]    <= '0;
                v_dly[i]    <= '0;
                flag_dly[i] <= '0;
            end
        end else begin
            h_dly[0]    <= h_cnt;
            v_dly[0]    <= v_cnt;
            flag_dly[0] <= flags;
            for (int i = 1; i < vision_pkg::PIPE_DELAY; i++) begin
                h_dly[i]    <= h_dly[i-1];
                v_dly[i]    <= v_dly[i-1];
                flag_dly[i] <= flag_dly[i-1];
            end
        end
    end

    assign hcount_o = h_dly[vision_pkg::PIPE_DELAY-1];
    assign vcount_o = v_dly[vision_pkg::PIPE_DELAY-1];
    assign {active_o, hsync_o, vsync_o, new_frame_o} = flag_dly[vision_pkg::PIPE_DELAY-1];

endmodule

/* hdl/frame_downscale_writer.sv */
`timescale 1ns/1ps

module frame_downscale_writer (
    input  logic                 clk_pixel,
    input  logic                 recent_reset,
    pixel_if.sink                cam,
    output logic                 fb_we_o,
    output vision_pkg::fb_addr_t fb_addr_o,
    output vision_pkg::rgb565_t  fb_data_o
);

    logic in_area;
    logic on_grid;
    logic keep;

    assign in_area = (cam.hcount < vision_pkg::H_ACTIVE) && (cam.vcount < vision_pkg::V_ACTIVE);

    // Column and row both multiples of four
    assign on_grid = (cam.hcount[vision_pkg::SCALE_SHIFT-1:0] == '0) &&
                     (cam.vcount[vision_pkg::SCALE_SHIFT-1:0] == '0);

    assign keep = cam.valid && in_area && on_grid;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            fb_we_o <= 1'b0;
        end else begin
            fb_we_o <= keep;
        end
    end

    // Only updated for kept pixels
    always_ff @(posedge clk_pixel) begin
        if (keep) begin
            fb_addr_o <= vision_pkg::fb_addr_t'(cam.hcount >> vision_pkg::SCALE_SHIFT) +
                         vision_pkg::fb_addr_t'((cam.vcount >> vision_pkg::SCALE_SHIFT) *
                                                vision_pkg::FB_WIDTH);
            fb_data_o <= cam.pixel;
        end
    end

endmodule

/* hdl/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer (
    input  logic                 clk_pixel,
    input  logic                 we_i,
    input  vision_pkg::fb_addr_t wr_addr_i,
    input  vision_pkg::rgb565_t  wr_data_i,
    input  vision_pkg::fb_addr_t rd_addr_i,
    output vision_pkg::rgb565_t  rd_data_o
);

    vision_pkg::rgb565_t mem [vision_pkg::FB_DEPTH];   // One word per stored pixel

    always_ff @(posedge clk_pixel) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Read-first on a same-address collision
    always_ff @(posedge clk_pixel) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* hdl/pixel_classify.sv */
`timescale 1ns/1ps

module pixel_classify (
    input  logic                      clk_pixel,
    input  logic                      recent_reset,
    input  vision_pkg::hcount_t       scan_h_i,
    input  vision_pkg::vcount_t       scan_v_i,
    input  logic                      scan_active_i,
    input  vision_pkg::rgb565_t       rd_data_i,
    input  vision_pkg::channel_t      lower_i,
    input  vision_pkg::channel_t      upper_i,
    input  vision_pkg::display_mode_t mode_i,
    output vision_pkg::fb_addr_t      rd_addr_o,
    output vision_pkg::channel_t      red_o,
    output vision_pkg::channel_t      green_o,
    output vision_pkg::channel_t      blue_o
);

    logic                 active_q1;
    logic                 active_q2;   // Lines up with rd_data_i
    vision_pkg::channel_t red_x, green_x, blue_x;
    logic [15:0]          luma_sum;
    vision_pkg::channel_t luma;
    logic                 mask;
    vision_pkg::channel_t red_d, green_d, blue_d;

    // Stage one: each stored pixel covers a 4x4 block
    always_ff @(posedge clk_pixel) begin
        rd_addr_o <= vision_pkg::fb_addr_t'(scan_h_i >> vision_pkg::SCALE_SHIFT) +
                     vision_pkg::fb_addr_t'((scan_v_i >> vision_pkg::SCALE_SHIFT) *
                                            vision_pkg::FB_WIDTH);
    end

    assign red_x   = {rd_data_i[15:11], 3'b000};
    assign green_x = {rd_data_i[10:5], 2'b00};
    assign blue_x  = {rd_data_i[4:0], 3'b000};

    // Integer BT.601 weights, sum of weights is 256
    assign luma_sum = 8'd77 * red_x + 8'd150 * green_x + 8'd29 * blue_x;
    assign luma     = luma_sum[15:8];
    assign mask     = (luma > lower_i) && (luma <= upper_i);

    always_comb begin
        case (mode_i)
            vision_pkg::MODE_GREY: {red_d, green_d, blue_d} = {luma, luma, luma};
            vision_pkg::MODE_MASK: {red_d, green_d, blue_d} = mask ? 24'hffffff : 24'h000000;
            default:               {red_d, green_d, blue_d} = {red_x, green_x, blue_x};
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            active_q1 <= 1'b0;
            active_q2 <= 1'b0;
            red_o     <= '0;
            green_o   <= '0;
            blue_o    <= '0;
        end else begin
            active_q1 <= scan_active_i;
            active_q2 <= active_q1;
            red_o     <= active_q2 ? red_d : '0;   // Black during blanking
            green_o   <= active_q2 ? green_d : '0;
            blue_o    <= active_q2 ? blue_d : '0;
        end
    end

endmodule

/* hdl/vision_top.sv */
`timescale 1ns/1ps

module vision_top (
    input  logic                 clk_pixel,
    input  logic                 recent_reset,
    input  logic                 cam_valid_i,
    input  vision_pkg::hcount_t  cam_hcount_i,
    input  vision_pkg::vcount_t  cam_vcount_i,
    input  vision_pkg::rgb565_t  cam_pixel_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  vision_pkg::wb_adr_t  wb_adr_i,
    input  vision_pkg::wb_data_t wb_dat_i,
    output vision_pkg::wb_data_t wb_dat_o,
    output logic                 wb_ack_o,
    output vision_pkg::channel_t red_o,
    output vision_pkg::channel_t green_o,
    output vision_pkg::channel_t blue_o,
    output vision_pkg::hcount_t  hcount_o,
    output vision_pkg::vcount_t  vcount_o,
    output logic                 active_o,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 new_frame_o
);

    pixel_if cam_bus ();

    vision_pkg::channel_t      lower, upper;
    vision_pkg::display_mode_t mode;
    vision_pkg::hcount_t       scan_h;
    vision_pkg::vcount_t       scan_v;
    logic                      scan_active;
    logic                      fb_we;
    vision_pkg::fb_addr_t      fb_wr_addr, fb_rd_addr;
    vision_pkg::rgb565_t       fb_wr_data, fb_rd_data;

    // Camera ports onto the stream bundle
    assign cam_bus.valid  = cam_valid_i;
    assign cam_bus.hcount = cam_hcount_i;
    assign cam_bus.vcount = cam_vcount_i;
    assign cam_bus.pixel  = cam_pixel_i;

    wb_ctrl_regs u_regs (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .lower_o(lower), .upper_o(upper), .mode_o(mode));

    video_timing u_timing (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .scan_h_o(scan_h), .scan_v_o(scan_v), .scan_active_o(scan_active),
        .hcount_o(hcount_o), .vcount_o(vcount_o), .active_o(active_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .new_frame_o(new_frame_o));

    frame_downscale_writer u_writer (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset), .cam(cam_bus.sink),
        .fb_we_o(fb_we), .fb_addr_o(fb_wr_addr), .fb_data_o(fb_wr_data));

    frame_buffer u_fb (
        .clk_pixel(clk_pixel), .we_i(fb_we), .wr_addr_i(fb_wr_addr),
        .wr_data_i(fb_wr_data), .rd_addr_i(fb_rd_addr), .rd_data_o(fb_rd_data));

    pixel_classify u_classify (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .scan_h_i(scan_h), .scan_v_i(scan_v), .scan_active_i(scan_active),
        .rd_data_i(fb_rd_data), .lower_i(lower), .upper_i(upper), .mode_i(mode),
        .rd_addr_o(fb_rd_addr), .red_o(red_o), .green_o(green_o), .blue_o(blue_o));

endmodule

/* tests/tb_vision_top.sv */
`timescale 1ns/1ps

module tb_vision_top;

    localparam int CLK_HALF      = 20;   // 40 ns pixel clock
    localparam int RESET_CYCLES  = 8;
    localparam int ACK_TIMEOUT   = 16;
    localparam int FRAME_CYCLES  = int'(vision_pkg::H_TOTAL) * int'(vision_pkg::V_TOTAL);
    localparam int FRAME_TIMEOUT = 2 * FRAME_CYCLES;

    logic                      clk_pixel;
    logic                      recent_reset;
    logic                      cam_valid_i;
    vision_pkg::hcount_t       cam_hcount_i;
    vision_pkg::vcount_t       cam_vcount_i;
    vision_pkg::rgb565_t       cam_pixel_i;
    logic                      wb_cyc_i, wb_stb_i, wb_we_i;
    vision_pkg::wb_adr_t       wb_adr_i;
    vision_pkg::wb_data_t      wb_dat_i, wb_dat_o;
    logic                      wb_ack_o;
    vision_pkg::channel_t      red_o, green_o, blue_o;
    vision_pkg::hcount_t       hcount_o;
    vision_pkg::vcount_t       vcount_o;
    logic                      active_o, hsync_o, vsync_o, new_frame_o;

    integer                    seed;
    vision_pkg::rgb565_t       model_fb [vision_pkg::FB_DEPTH];   // Expected stored frame
    vision_pkg::display_mode_t cur_mode;
    int                        cur_lower, cur_upper;
    int                        white_seen, black_seen;

    vision_top u_vision_top (.*);

    initial begin
        clk_pixel = 1'b0;
        forever begin
            #CLK_HALF clk_pixel = ~clk_pixel;
        end
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1, "Stopped on a timeout");
    endtask

    // One Wishbone classic access, strobe held one cycle past the ack
    task automatic wb_access(input logic we, input vision_pkg::wb_adr_t adr,
                             input vision_pkg::wb_data_t wdata,
                             output vision_pkg::wb_data_t rdata);
        int waited;
        @(negedge clk_pixel);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        waited   = 0;
        while (!wb_ack_o) begin
            if (waited == ACK_TIMEOUT) report_timeout("the Wishbone acknowledge");
            @(negedge clk_pixel);
            waited++;
        end
        rdata = wb_dat_o;
        @(negedge clk_pixel);
        assert (!wb_ack_o) else report_error("wb_ack_o stayed high for a second cycle");
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic reg_write(input vision_pkg::wb_adr_t adr, input vision_pkg::wb_data_t data);
        vision_pkg::wb_data_t ignored;
        wb_access(1'b1, adr, data, ignored);
    endtask

    task automatic reg_expect(input vision_pkg::wb_adr_t adr, input vision_pkg::wb_data_t exp);
        vision_pkg::wb_data_t got;
        wb_access(1'b0, adr, 8'h00, got);
        assert (got == exp) else
            report_error($sformatf("register %0d read 0x%02h, expected 0x%02h", adr, got, exp));
    endtask

    function automatic logic [23:0] expand_rgb(input vision_pkg::rgb565_t p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic int luma_of(input vision_pkg::rgb565_t p);
        logic [23:0] c;
        c = expand_rgb(p);
        return (77 * int'(c[23:16]) + 150 * int'(c[15:8]) + 29 * int'(c[7:0])) / 256;
    endfunction

    function automatic logic [23:0] expected_pixel(input int h, input int v);
        vision_pkg::rgb565_t p;
        int                  y;
        p = model_fb[h / 4 + (v / 4) * vision_pkg::FB_WIDTH];   // 4x upscale
        y = luma_of(p);
        case (cur_mode)
            vision_pkg::MODE_GREY: return {y[7:0], y[7:0], y[7:0]};
            vision_pkg::MODE_MASK: return (y > cur_lower && y <= cur_upper) ? 24'hffffff : 24'h0;
            default:               return expand_rgb(p);
        endcase
    endfunction

    task automatic check_quiet_outputs();
        assert (!active_o && !wb_ack_o) else report_error("active_o or wb_ack_o high after reset");
        assert (!hsync_o && !vsync_o && !new_frame_o) else
            report_error("sync or frame start high after reset");
        assert ({red_o, green_o, blue_o} == 24'h0) else report_error("pixel outputs not zero");
    endtask

    task automatic check_output_pixel();
        logic [23:0] got, exp;
        int          h, v;
        logic        exp_hsync, exp_vsync;
        h   = int'(hcount_o);
        v   = int'(vcount_o);
        got = {red_o, green_o, blue_o};
        exp_hsync = (h >= int'(vision_pkg::H_SYNC_START)) && (h < int'(vision_pkg::H_SYNC_END));
        exp_vsync = (v >= int'(vision_pkg::V_SYNC_START)) && (v < int'(vision_pkg::V_SYNC_END));
        assert (active_o == (h < vision_pkg::H_ACTIVE && v < vision_pkg::V_ACTIVE)) else
            report_error($sformatf("active_o is %0b at (%0d,%0d)", active_o, h, v));
        assert (hsync_o == exp_hsync) else
            report_error($sformatf("hsync_o is %0b at (%0d,%0d)", hsync_o, h, v));
        assert (vsync_o == exp_vsync) else
            report_error($sformatf("vsync_o is %0b at (%0d,%0d)", vsync_o, h, v));
        if (active_o) begin
            exp = expected_pixel(h, v);
            assert (got == exp) else
                report_error($sformatf("pixel (%0d,%0d) is %06h, expected %06h", h, v, got, exp));
            if (cur_mode == vision_pkg::MODE_MASK) begin
                if (exp == 24'h0) black_seen++;
                else white_seen++;
            end
        end else begin
            assert (got == 24'h0) else
                report_error($sformatf("blanking pixel (%0d,%0d) is %06h", h, v, got));
        end
        if (new_frame_o) begin
            assert (h == 0 && v == 0) else
                report_error($sformatf("new_frame_o at (%0d,%0d)", h, v));
        end
    endtask

    task automatic wait_new_frame();
        int waited;
        waited = 0;
        do begin
            @(negedge clk_pixel);
            waited++;
            if (waited > FRAME_TIMEOUT) report_timeout("new_frame_o");
        end while (!new_frame_o);
    endtask

    // Checks one whole frame, from one frame start up to the next
    task automatic check_frame();
        int cycles;
        wait_new_frame();
        cycles = 0;
        do begin
            check_output_pixel();
            @(negedge clk_pixel);
            cycles++;
            if (cycles > FRAME_TIMEOUT) report_timeout("the next frame start");
        end while (!new_frame_o);
        assert (cycles == FRAME_CYCLES) else
            report_error($sformatf("frame lasted %0d cycles, expected %0d", cycles, FRAME_CYCLES));
    endtask

    task automatic send_camera_frame();
        vision_pkg::rgb565_t pix;
        for (int v = 0; v < int'(vision_pkg::V_ACTIVE); v++) begin
            for (int h = 0; h < int'(vision_pkg::H_ACTIVE); h++) begin
                @(negedge clk_pixel);
                pix          = vision_pkg::rgb565_t'($random(seed));
                cam_valid_i  = 1'b1;
                cam_hcount_i = vision_pkg::hcount_t'(h);
                cam_vcount_i = vision_pkg::vcount_t'(v);
                cam_pixel_i  = pix;
                if (h % 4 == 0 && v % 4 == 0) begin
                    model_fb[h / 4 + (v / 4) * vision_pkg::FB_WIDTH] = pix;   // Kept by 4x downscale
                end
            end
        end
        @(negedge clk_pixel);
        cam_valid_i = 1'b0;
    endtask

    initial begin
        seed         = 32'had3b9c5b;
        recent_reset = 1'b1;
        cam_valid_i  = 1'b0;
        cam_hcount_i = '0;
        cam_vcount_i = '0;
        cam_pixel_i  = '0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        cur_mode     = vision_pkg::MODE_CAMERA;
        cur_lower    = 240;
        cur_upper    = 255;
        white_seen   = 0;
        black_seen   = 0;

        repeat (RESET_CYCLES) @(negedge clk_pixel);
        check_quiet_outputs();
        recent_reset = 1'b0;
        @(negedge clk_pixel);
        check_quiet_outputs();   // Pipeline still filling

        reg_expect(vision_pkg::REG_LOWER, 8'd240);
        reg_expect(vision_pkg::REG_UPPER, 8'd255);
        reg_expect(vision_pkg::REG_MODE, 8'd0);

        reg_write(vision_pkg::REG_LOWER, 8'h5a);
        reg_write(vision_pkg::REG_UPPER, 8'hc3);
        reg_write(vision_pkg::REG_MODE, 8'hfe);   // Only the low two bits stay
        reg_write(4'd5, 8'hff);
        reg_expect(vision_pkg::REG_LOWER, 8'h5a);
        reg_expect(vision_pkg::REG_UPPER, 8'hc3);
        reg_expect(vision_pkg::REG_MODE, 8'h02);
        reg_expect(4'd5, 8'h00);

        reg_write(vision_pkg::REG_MODE, 8'h00);
        cur_mode = vision_pkg::MODE_CAMERA;
        send_camera_frame();
        check_frame();

        reg_write(vision_pkg::REG_MODE, 8'h01);
        cur_mode = vision_pkg::MODE_GREY;
        check_frame();

        // Window in the middle of the luma range
        reg_write(vision_pkg::REG_LOWER, 8'd100);
        reg_write(vision_pkg::REG_UPPER, 8'd180);
        reg_write(vision_pkg::REG_MODE, 8'h02);
        cur_lower = 100;
        cur_upper = 180;
        cur_mode  = vision_pkg::MODE_MASK;
        check_frame();
        assert (white_seen > 0 && black_seen > 0) else
            report_error($sformatf("mask frame had %0d white and %0d black pixels",
                                   white_seen, black_seen));

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* all.f */
hdl/vision_pkg.sv
hdl/pixel_if.sv
hdl/wb_ctrl_regs.sv
hdl/video_timing.sv
hdl/frame_downscale_writer.sv
hdl/frame_buffer.sv
hdl/pixel_classify.sv
hdl/vision_top.sv
tests/tb_vision_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vision_top -f all.f -o tb_vision_top

out=$(./obj_dir/tb_vision_top 2>&1) || true
echo "$out"
echo "$out" | grep -qx "TEST PASSED"
